//--- common/axi_mon_pkg.sv
// Shared AXI4 monitor definitions; imported by the decode, execute and result blocks
package axi_mon_pkg;

   // Fixed AXI4 field widths
   localparam int LEN_W  = 8;  // AxLEN
   localparam int SIZE_W = 3;  // AxSIZE

   // AxBURST encodings, reserved value 3 is treated like INCR
   typedef enum logic [1:0] {
      FIXED = 2'd0,
      INCR  = 2'd1,
      WRAP  = 2'd2
   } burst_e;

   // Violation codes, lower code wins when several fire together
   typedef enum logic [2:0] {
      W_LAST_MISSING = 3'd0,  // No WLAST on final write beat
      W_LAST_EARLY   = 3'd1,  // WLAST before final write beat
      W_STRB_LANE    = 3'd2,  // Strobe outside active byte lanes
      B_EARLY        = 3'd3,  // Response with no finished burst
      R_UNEXPECTED   = 3'd4,  // Read data with no outstanding read
      R_LAST_MISSING = 3'd5,  // No RLAST on final read beat
      R_LAST_EARLY   = 3'd6   // RLAST before final read beat
   } viol_e;

   localparam int NUM_VIOL = 7;

   // Bit n set means code n seen
   typedef logic [NUM_VIOL-1:0] viol_mask_t;

endpackage

//--- decode/chan_decode.sv
// Captures AXI4 handshakes on all five channels and presents them as registered events
`timescale 1ns/1ps

module chan_decode #(
   parameter int ID_W   = 2,
   parameter int ADDR_W = 16,
   parameter int STRB_W = 8
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          aw_valid,
   input  logic                          aw_ready,
   input  logic [ID_W-1:0]               aw_id,
   input  logic [ADDR_W-1:0]             aw_addr,
   input  logic [axi_mon_pkg::LEN_W-1:0] aw_len,
   input  logic [axi_mon_pkg::SIZE_W-1:0] aw_size,
   input  logic [1:0]                    aw_burst,
   input  logic                          w_valid,
   input  logic                          w_ready,
   input  logic [STRB_W-1:0]             w_strb,
   input  logic                          w_last,
   input  logic                          b_valid,
   input  logic                          b_ready,
   input  logic [ID_W-1:0]               b_id,
   input  logic                          ar_valid,
   input  logic                          ar_ready,
   input  logic [ID_W-1:0]               ar_id,
   input  logic [axi_mon_pkg::LEN_W-1:0] ar_len,
   input  logic                          r_valid,
   input  logic                          r_ready,
   input  logic [ID_W-1:0]               r_id,
   input  logic                          r_last,
   output logic                          aw_evt,
   output logic [ID_W-1:0]               aw_id_q,
   output logic [ADDR_W-1:0]             aw_addr_q,
   output logic [axi_mon_pkg::LEN_W-1:0] aw_len_q,
   output logic [axi_mon_pkg::SIZE_W-1:0] aw_size_q,
   output axi_mon_pkg::burst_e           aw_burst_q,
   output logic                          w_evt,
   output logic [STRB_W-1:0]             w_strb_q,
   output logic                          w_last_q,
   output logic                          b_evt,
   output logic [ID_W-1:0]               b_id_q,
   output logic                          ar_evt,
   output logic [ID_W-1:0]               ar_id_q,
   output logic [axi_mon_pkg::LEN_W-1:0] ar_len_q,
   output logic                          r_evt,
   output logic [ID_W-1:0]               r_id_q,
   output logic                          r_last_q
);
   import axi_mon_pkg::*;

   logic aw_hs, w_hs, b_hs, ar_hs, r_hs;

   // A transfer happens only when both sides agree
   assign aw_hs = aw_valid & aw_ready;
   assign w_hs  = w_valid & w_ready;
   assign b_hs  = b_valid & b_ready;
   assign ar_hs = ar_valid & ar_ready;
   assign r_hs  = r_valid & r_ready;

   // Event strobes, one cycle behind the bus
   always_ff @(posedge clk) begin
      if (rst_n) begin
         aw_evt <= 1'b0;
         w_evt  <= 1'b0;
         b_evt  <= 1'b0;
         ar_evt <= 1'b0;
         r_evt  <= 1'b0;
      end else begin
         aw_evt <= aw_hs;
         w_evt  <= w_hs;
         b_evt  <= b_hs;
         ar_evt <= ar_hs;
         r_evt  <= r_hs;
      end
   end

   // Fields hold their last accepted value between events
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         aw_id_q    <= aw_id;
         aw_addr_q  <= aw_addr;
         aw_len_q   <= aw_len;
         aw_size_q  <= aw_size;
         aw_burst_q <= burst_e'(aw_burst);  // Raw bus bits to burst type
      end
      if (w_hs) begin
         w_strb_q <= w_strb;
         w_last_q <= w_last;
      end
      if (b_hs) b_id_q <= b_id;
      if (ar_hs) begin
         ar_id_q  <= ar_id;
         ar_len_q <= ar_len;
      end
      if (r_hs) begin
         r_id_q   <= r_id;
         r_last_q <= r_last;
      end
   end

endmodule

//--- execute/read_check.sv
// Read-side checker; keeps a length queue per ID and flags stray R beats and RLAST errors
`timescale 1ns/1ps

module read_check #(
   parameter int ID_W       = 2,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          ar_evt,
   input  logic [ID_W-1:0]               ar_id_q,
   input  logic [axi_mon_pkg::LEN_W-1:0] ar_len_q,
   input  logic                          r_evt,
   input  logic [ID_W-1:0]               r_id_q,
   input  logic                          r_last_q,
   output axi_mon_pkg::viol_mask_t       r_viol
);
   import axi_mon_pkg::*;

   localparam int NUM_ID = 2 ** ID_W;

   typedef logic [LEN_W-1:0] len_t;

   len_t              len_head [NUM_ID];   // ARLEN of oldest read per ID
   len_t              beat_cnt [NUM_ID];   // Beats seen per ID
   logic [NUM_ID-1:0] q_empty, r_push, r_pop, r_beat;
   logic              r_chk, last_beat, r_end;

   // Interleaving across IDs is legal, so one queue each
   for (genvar i = 0; i < NUM_ID; i++) begin : g_id
      burst_fifo #(
         .item_t (len_t),
         .DEPTH  (FIFO_DEPTH)
      ) u_len_fifo (
         .clk       (clk),
         .rst_n     (rst_n),
         .push      (r_push[i]),
         .push_item (ar_len_q),
         .pop       (r_pop[i]),
         .head      (len_head[i]),
         .empty     (q_empty[i])
      );
   end

   assign r_chk     = r_evt & ~q_empty[r_id_q];
   assign last_beat = (beat_cnt[r_id_q] == len_head[r_id_q]);
   assign r_end     = r_chk & (last_beat | r_last_q);

   always_comb begin
      r_viol                 = '0;
      r_viol[R_UNEXPECTED]   = r_evt & q_empty[r_id_q];
      r_viol[R_LAST_MISSING] = r_chk & last_beat & ~r_last_q;
      r_viol[R_LAST_EARLY]   = r_chk & ~last_beat & r_last_q;
      for (int i = 0; i < NUM_ID; i++) begin
         r_push[i] = ar_evt & (ar_id_q == ID_W'(i));
         r_beat[i] = r_chk & (r_id_q == ID_W'(i));
         r_pop[i]  = r_end & (r_id_q == ID_W'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_ID; i++) begin
         if (rst_n) begin
            beat_cnt[i] <= '0;
         end else if (r_pop[i]) begin
            beat_cnt[i] <= '0;   // Either burst end restarts the count
         end else if (r_beat[i]) begin
            beat_cnt[i] <= beat_cnt[i] + 1'b1;
         end
      end
   end

endmodule

//--- execute/strobe_lanes.sv
// Byte lane and address step logic for one write beat, used by the write checker
`timescale 1ns/1ps

module strobe_lanes #(
   parameter int ADDR_W = 16,
   parameter int STRB_W = 8    // Power of two, at least 2
) (
   input  logic [ADDR_W-1:0]              addr,
   input  logic [axi_mon_pkg::SIZE_W-1:0] size,
   input  axi_mon_pkg::burst_e            burst,
   input  logic [axi_mon_pkg::LEN_W-1:0]  len,
   output logic [STRB_W-1:0]              lane_mask,
   output logic [ADDR_W-1:0]              next_addr
);
   import axi_mon_pkg::*;

   localparam int LANE_W = $clog2(STRB_W);

   logic [ADDR_W-1:0] nbytes;     // Bytes per transfer
   logic [ADDR_W-1:0] aligned;    // Address rounded down to transfer size
   logic [ADDR_W-1:0] incr_addr;
   logic [ADDR_W-1:0] total;      // Bytes in whole wrap burst
   logic [ADDR_W-1:0] wrap_base;
   logic [LANE_W-1:0] lower, upper;

   assign nbytes    = ADDR_W'(1) << size;
   assign aligned   = addr & ~(nbytes - 1'b1);
   assign lower     = addr[LANE_W-1:0];
   assign upper     = LANE_W'(aligned + nbytes - 1'b1);  // Modulo bus width
   assign incr_addr = aligned + nbytes;
   assign total     = nbytes * (ADDR_W'(len) + 1'b1);
   assign wrap_base = addr & ~(total - 1'b1);

   // Only lanes from lower to upper may carry data
   always_comb begin
      for (int i = 0; i < STRB_W; i++) begin
         lane_mask[i] = (LANE_W'(i) >= lower) && (LANE_W'(i) <= upper);
      end
   end

   always_comb begin
      case (burst)
         FIXED:   next_addr = aligned;          // Later beats use aligned address
         WRAP:    next_addr = (incr_addr == wrap_base + total) ? wrap_base : incr_addr;
         default: next_addr = incr_addr;        // INCR and reserved
      endcase
   end

endmodule

//--- execute/write_check.sv
// Write-side checker; follows AW bursts beat by beat and flags WLAST, WSTRB and early B
`timescale 1ns/1ps

module write_check #(
   parameter int ID_W       = 2,
   parameter int ADDR_W     = 16,
   parameter int STRB_W     = 8,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           aw_evt,
   input  logic [ID_W-1:0]                aw_id_q,
   input  logic [ADDR_W-1:0]              aw_addr_q,
   input  logic [axi_mon_pkg::LEN_W-1:0]  aw_len_q,
   input  logic [axi_mon_pkg::SIZE_W-1:0] aw_size_q,
   input  axi_mon_pkg::burst_e            aw_burst_q,
   input  logic                           w_evt,
   input  logic [STRB_W-1:0]              w_strb_q,
   input  logic                           w_last_q,
   input  logic                           b_evt,
   input  logic [ID_W-1:0]                b_id_q,
   output axi_mon_pkg::viol_mask_t        w_viol
);
   import axi_mon_pkg::*;

   localparam int NUM_ID = 2 ** ID_W;
   localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

   // Burst descriptor kept per accepted AW
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic [SIZE_W-1:0] size;
      burst_e            burst;
   } desc_t;

   desc_t             head, aw_desc;
   logic              q_empty;
   logic [LEN_W-1:0]  beat_cnt;                  // Beats seen in head burst
   logic [ADDR_W-1:0] cur_addr, beat_addr, next_addr;
   logic [STRB_W-1:0] lane_mask;
   logic              w_chk, last_beat, burst_end;
   logic [NUM_ID-1:0] done_inc, done_dec;
   logic [CNT_W-1:0]  done_cnt [NUM_ID];         // Finished bursts awaiting B

   assign aw_desc = '{id: aw_id_q, addr: aw_addr_q, len: aw_len_q,
                      size: aw_size_q, burst: aw_burst_q};

   burst_fifo #(
      .item_t (desc_t),
      .DEPTH  (FIFO_DEPTH)
   ) u_desc_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (aw_evt),
      .push_item (aw_desc),
      .pop       (burst_end),
      .head      (head),
      .empty     (q_empty)
   );

   assign beat_addr = (beat_cnt == '0) ? head.addr : cur_addr;  // First beat uses AWADDR

   strobe_lanes #(
      .ADDR_W (ADDR_W),
      .STRB_W (STRB_W)
   ) u_lanes (
      .addr      (beat_addr),
      .size      (head.size),
      .burst     (head.burst),
      .len       (head.len),
      .lane_mask (lane_mask),
      .next_addr (next_addr)
   );

   assign w_chk     = w_evt & ~q_empty;   // Stray beats are ignored
   assign last_beat = (beat_cnt == head.len);
   assign burst_end = w_chk & (last_beat | w_last_q);  // Early WLAST also closes the burst

   always_comb begin
      w_viol                 = '0;
      w_viol[W_LAST_MISSING] = w_chk & last_beat & ~w_last_q;
      w_viol[W_LAST_EARLY]   = w_chk & ~last_beat & w_last_q;
      w_viol[W_STRB_LANE]    = w_chk & |(w_strb_q & ~lane_mask);
      w_viol[B_EARLY]        = b_evt & (done_cnt[b_id_q] == '0);
      for (int i = 0; i < NUM_ID; i++) begin
         done_inc[i] = burst_end & (head.id == ID_W'(i));
         done_dec[i] = b_evt & (b_id_q == ID_W'(i)) & (done_cnt[i] != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (rst_n) begin
         beat_cnt <= '0;
      end else if (burst_end) begin
         beat_cnt <= '0;
      end else if (w_chk) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Address of the following beat
   always_ff @(posedge clk) begin
      if (w_chk) cur_addr <= next_addr;
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_ID; i++) begin
         if (rst_n) begin
            done_cnt[i] <= '0;
         end else begin
            done_cnt[i] <= done_cnt[i] + CNT_W'(done_inc[i]) - CNT_W'(done_dec[i]);
         end
      end
   end

endmodule

//--- project.f
common/axi_mon_pkg.sv
src/burst_fifo.sv
execute/strobe_lanes.sv
decode/chan_decode.sv
execute/write_check.sv
execute/read_check.sv
result/viol_report.sv
src/axi_mon_top.sv
test/tb_clock.sv
test/tb_axi_mon.sv

//--- result/viol_report.sv
// Merges checker flags into a one-cycle coded violation pulse and a sticky mask
`timescale 1ns/1ps

module viol_report (
   input  logic                    clk,
   input  logic                    rst_n,
   input  axi_mon_pkg::viol_mask_t w_viol,
   input  axi_mon_pkg::viol_mask_t r_viol,
   output logic                    viol_valid,
   output axi_mon_pkg::viol_e      viol_code,
   output axi_mon_pkg::viol_mask_t viol_mask
);
   import axi_mon_pkg::*;

   viol_mask_t flags;
   viol_e      low_code;

   assign flags = w_viol | r_viol;

   // Lowest set code wins, scan from the top down
   always_comb begin
      low_code = W_LAST_MISSING;
      for (int i = NUM_VIOL - 1; i >= 0; i--) begin
         if (flags[i]) low_code = viol_e'(i);
      end
   end

   always_ff @(posedge clk) begin
      if (rst_n) begin
         viol_valid <= 1'b0;
         viol_mask  <= '0;
      end else begin
         viol_valid <= |flags;
         viol_mask  <= viol_mask | flags;   // Sticky until reset
      end
   end

   // Code is only meaningful with viol_valid
   always_ff @(posedge clk) begin
      viol_code <= low_code;
   end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the AXI4 monitor testbench with Verilator and runs it; exit status is the result
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_axi_mon \
   --Mdir obj_dir -o tb_axi_mon_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_axi_mon_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation run failed with status $status"
   exit "$status"
fi

exit 0

//--- src/axi_mon_top.sv
// AXI4 protocol monitor top level; wires channel capture, checkers and violation report
`timescale 1ns/1ps

module axi_mon_top #(
   parameter int ID_W       = 2,
   parameter int ADDR_W     = 16,
   parameter int STRB_W     = 8,   // Data bus bytes
   parameter int FIFO_DEPTH = 4    // Outstanding bursts per queue
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           aw_valid,
   input  logic                           aw_ready,
   input  logic [ID_W-1:0]                aw_id,
   input  logic [ADDR_W-1:0]              aw_addr,
   input  logic [axi_mon_pkg::LEN_W-1:0]  aw_len,
   input  logic [axi_mon_pkg::SIZE_W-1:0] aw_size,
   input  logic [1:0]                     aw_burst,
   input  logic                           w_valid,
   input  logic                           w_ready,
   input  logic [STRB_W-1:0]              w_strb,
   input  logic                           w_last,
   input  logic                           b_valid,
   input  logic                           b_ready,
   input  logic [ID_W-1:0]                b_id,
   input  logic                           ar_valid,
   input  logic                           ar_ready,
   input  logic [ID_W-1:0]                ar_id,
   input  logic [axi_mon_pkg::LEN_W-1:0]  ar_len,
   input  logic                           r_valid,
   input  logic                           r_ready,
   input  logic [ID_W-1:0]                r_id,
   input  logic                           r_last,
   output logic                           viol_valid,
   output axi_mon_pkg::viol_e             viol_code,
   output axi_mon_pkg::viol_mask_t        viol_mask
);
   import axi_mon_pkg::*;

   // Registered channel events
   logic              aw_evt, w_evt, b_evt, ar_evt, r_evt;
   logic [ID_W-1:0]   aw_id_q, b_id_q, ar_id_q, r_id_q;
   logic [ADDR_W-1:0] aw_addr_q;
   logic [LEN_W-1:0]  aw_len_q, ar_len_q;
   logic [SIZE_W-1:0] aw_size_q;
   burst_e            aw_burst_q;
   logic [STRB_W-1:0] w_strb_q;
   logic              w_last_q, r_last_q;
   viol_mask_t        w_viol, r_viol;   // Same-cycle checker flags

   chan_decode #(
      .ID_W   (ID_W),
      .ADDR_W (ADDR_W),
      .STRB_W (STRB_W)
   ) u_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .aw_id      (aw_id),
      .aw_addr    (aw_addr),
      .aw_len     (aw_len),
      .aw_size    (aw_size),
      .aw_burst   (aw_burst),
      .w_valid    (w_valid),
      .w_ready    (w_ready),
      .w_strb     (w_strb),
      .w_last     (w_last),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .b_id       (b_id),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .ar_id      (ar_id),
      .ar_len     (ar_len),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_id       (r_id),
      .r_last     (r_last),
      .aw_evt     (aw_evt),
      .aw_id_q    (aw_id_q),
      .aw_addr_q  (aw_addr_q),
      .aw_len_q   (aw_len_q),
      .aw_size_q  (aw_size_q),
      .aw_burst_q (aw_burst_q),
      .w_evt      (w_evt),
      .w_strb_q   (w_strb_q),
      .w_last_q   (w_last_q),
      .b_evt      (b_evt),
      .b_id_q     (b_id_q),
      .ar_evt     (ar_evt),
      .ar_id_q    (ar_id_q),
      .ar_len_q   (ar_len_q),
      .r_evt      (r_evt),
      .r_id_q     (r_id_q),
      .r_last_q   (r_last_q)
   );

   write_check #(
      .ID_W       (ID_W),
      .ADDR_W     (ADDR_W),
      .STRB_W     (STRB_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_write_check (
      .clk        (clk),
      .rst_n      (rst_n),
      .aw_evt     (aw_evt),
      .aw_id_q    (aw_id_q),
      .aw_addr_q  (aw_addr_q),
      .aw_len_q   (aw_len_q),
      .aw_size_q  (aw_size_q),
      .aw_burst_q (aw_burst_q),
      .w_evt      (w_evt),
      .w_strb_q   (w_strb_q),
      .w_last_q   (w_last_q),
      .b_evt      (b_evt),
      .b_id_q     (b_id_q),
      .w_viol     (w_viol)
   );

   read_check #(
      .ID_W       (ID_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_read_check (
      .clk      (clk),
      .rst_n    (rst_n),
      .ar_evt   (ar_evt),
      .ar_id_q  (ar_id_q),
      .ar_len_q (ar_len_q),
      .r_evt    (r_evt),
      .r_id_q   (r_id_q),
      .r_last_q (r_last_q),
      .r_viol   (r_viol)
   );

   // Pulse lands two cycles after the handshake
   viol_report u_report (
      .clk        (clk),
      .rst_n      (rst_n),
      .w_viol     (w_viol),
      .r_viol     (r_viol),
      .viol_valid (viol_valid),
      .viol_code  (viol_code),
      .viol_mask  (viol_mask)
   );

endmodule

//--- src/burst_fifo.sv
// Small synchronous FIFO with a type-parameter payload, holds outstanding burst info
`timescale 1ns/1ps

module burst_fifo #(
   parameter type item_t = logic,
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push,
   input  item_t push_item,
   input  logic  pop,
   output item_t head,
   output logic  empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t             mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr, rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_push, do_pop;

   assign do_push = push & (count != CNT_W'(DEPTH));  // Full drops the push
   assign do_pop  = pop & ~empty;
   assign empty   = (count == '0);
   assign head    = mem[rd_ptr];                      // Oldest entry, no latency

   always_ff @(posedge clk) begin
      if (rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_item;
   end

endmodule

//--- test/tb_axi_mon.sv
// Testbench for the AXI4 monitor; random bursts with injected errors, checked every cycle
`timescale 1ns/1ps

module tb_axi_mon;
   import axi_mon_pkg::*;

   localparam int ID_W       = 2;
   localparam int ADDR_W     = 16;
   localparam int STRB_W     = 8;
   localparam int FIFO_DEPTH = 4;
   localparam int NUM_ID     = 2 ** ID_W;

   // Write burst as the model remembers it
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic [SIZE_W-1:0] size;
      logic [1:0]        burst;
   } wr_burst_t;

   logic clk, rst_n, rst_req;
   logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   logic ar_valid, ar_ready, r_valid, r_ready, w_last, r_last;
   logic [ID_W-1:0]   aw_id, b_id, ar_id, r_id;
   logic [ADDR_W-1:0] aw_addr;
   logic [LEN_W-1:0]  aw_len, ar_len;
   logic [SIZE_W-1:0] aw_size;
   logic [1:0]        aw_burst;
   logic [STRB_W-1:0] w_strb;
   logic              viol_valid;
   viol_e             viol_code;
   viol_mask_t        viol_mask;

   logic [31:0]       lfsr = 32'h9692;
   wr_burst_t         wq[$];            // Bursts with beats still to come
   int                w_beat;           // Beats seen in the head burst
   logic [ADDR_W-1:0] w_addr;           // Address of the next beat
   int                done [NUM_ID];    // Finished bursts waiting for B
   int                rq [NUM_ID][$];   // Outstanding read lengths per ID
   int                r_beat [NUM_ID];
   viol_mask_t        stage1, stage2;   // Predicted flags on their way to the outputs
   viol_mask_t        exp_mask;

   tb_clock clock0 (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

   axi_mon_top #(
      .ID_W(ID_W), .ADDR_W(ADDR_W), .STRB_W(STRB_W), .FIFO_DEPTH(FIFO_DEPTH)
   ) dut0 (
      .clk(clk), .rst_n(rst_n),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_id(aw_id), .aw_addr(aw_addr),
      .aw_len(aw_len), .aw_size(aw_size), .aw_burst(aw_burst),
      .w_valid(w_valid), .w_ready(w_ready), .w_strb(w_strb), .w_last(w_last),
      .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_id(ar_id), .ar_len(ar_len),
      .r_valid(r_valid), .r_ready(r_ready), .r_id(r_id), .r_last(r_last),
      .viol_valid(viol_valid), .viol_code(viol_code), .viol_mask(viol_mask)
   );

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      end
      return r;
   endfunction

   // Byte lanes a beat at address a may use
   function automatic logic [STRB_W-1:0] lanes_for(input logic [ADDR_W-1:0] a,
                                                   input logic [SIZE_W-1:0] size);
      int nbytes, lo, hi;
      logic [STRB_W-1:0] m;
      nbytes = 1 << size;
      lo     = int'(a) % STRB_W;
      hi     = ((int'(a) / nbytes) * nbytes + nbytes - 1) % STRB_W;
      m      = '0;
      for (int i = lo; i <= hi; i++) m[i] = 1'b1;
      return m;
   endfunction

   function automatic logic [ADDR_W-1:0] step_addr(input wr_burst_t d,
                                                   input logic [ADDR_W-1:0] a);
      int nbytes, aligned, total, base;
      nbytes  = 1 << d.size;
      aligned = (int'(a) / nbytes) * nbytes;
      total   = nbytes * (int'(d.len) + 1);
      base    = (int'(a) / total) * total;   // Wrap boundary
      if (d.burst == FIXED) return ADDR_W'(aligned);
      if (d.burst == WRAP && aligned + nbytes == base + total) return ADDR_W'(base);
      return ADDR_W'(aligned + nbytes);
   endfunction

   function automatic viol_e lowest_code(input viol_mask_t m);
      for (int i = 0; i < NUM_VIOL; i++) begin
         if (m[i]) return viol_e'(i);
      end
      return W_LAST_MISSING;
   endfunction

   function automatic int done_total();
      int s;
      s = 0;
      for (int i = 0; i < NUM_ID; i++) s += done[i];
      return s;
   endfunction

   function automatic bit model_idle();
      bit idle;
      idle = (wq.size() == 0) && (done_total() == 0);
      for (int i = 0; i < NUM_ID; i++) idle &= (rq[i].size() == 0);
      return idle;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_code(input string name, input logic exp_valid, input viol_e exp_code);
      string exp_s, act_s;
      exp_s = exp_valid ? exp_code.name() : "no violation";
      act_s = (viol_valid === 1'b1) ? viol_code.name() : "no violation";
      if (viol_valid !== exp_valid || (exp_valid && viol_code !== exp_code)) begin
         stop_with_failure($sformatf("error in %s at %0t: expected %s, actual %s",
                                     name, $time, exp_s, act_s));
      end
   endtask

   task automatic check_mask(input string name, input viol_mask_t exp);
      if (viol_mask !== exp) begin
         stop_with_failure($sformatf("error in %s at %0t: expected mask %b, actual mask %b",
                                     name, $time, exp, viol_mask));
      end
   endtask

   task automatic set_idle();
      {aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready} = '0;
      {ar_valid, ar_ready, r_valid, r_ready, w_last, r_last} = '0;
      {aw_id, b_id, ar_id, r_id, aw_len, ar_len, aw_size, aw_burst} = '0;
      aw_addr = '0;
      w_strb  = '0;
   endtask

   task automatic clear_model();
      wq.delete();
      w_beat = 0;
      w_addr = '0;
      for (int i = 0; i < NUM_ID; i++) begin
         rq[i].delete();
         done[i]   = 0;
         r_beat[i] = 0;
      end
      {stage1, stage2, exp_mask} = '0;
   endtask

   // One cycle of stimulus; the model sees B before W and pushes AW and AR last
   task automatic drive_cycle(input bit inject, input bit issue);
      viol_mask_t        f;
      wr_burst_t         d, aw_new;
      logic [ADDR_W-1:0] a;
      logic [STRB_W-1:0] lanes;
      bit                aw_go, ar_go, last;
      int                id, ar_pick, lane;
      f = '0;
      set_idle();
      aw_go   = issue && (wq.size() + done_total() < FIFO_DEPTH) && (rand_bits(1) == 1);
      ar_pick = rand_bits(ID_W);
      ar_go   = issue && (rq[ar_pick].size() < FIFO_DEPTH) && (rand_bits(1) == 1);
      if (aw_go) begin
         aw_new.id    = ID_W'(rand_bits(ID_W));
         aw_new.size  = SIZE_W'(rand_bits(2));   // Up to the full bus width
         aw_new.burst = 2'(rand_bits(2));
         if (aw_new.burst == 2'd3) aw_new.burst = INCR;
         aw_new.len   = LEN_W'(rand_bits(3));
         aw_new.addr  = ADDR_W'(rand_bits(12));   // Often narrow and unaligned
         if (aw_new.burst == WRAP) begin
            aw_new.len  = (LEN_W'(2) << (rand_bits(2) % 3)) - 1'b1;   // 1, 3 or 7
            aw_new.addr = aw_new.addr & ~((ADDR_W'(1) << aw_new.size) - 1'b1);
         end
         {aw_valid, aw_ready} = {1'b1, rand_bits(2) != 0};
         {aw_id, aw_addr, aw_len, aw_size, aw_burst} = aw_new;
      end
      if (ar_go) begin
         {ar_valid, ar_ready, ar_id} = {1'b1, rand_bits(2) != 0, ID_W'(ar_pick)};
         ar_len = LEN_W'(rand_bits(3));
      end
      if (rand_bits(1) == 1) begin
         id = rand_bits(ID_W);
         if (done[id] > 0 || (inject && rand_bits(2) == 0)) begin
            {b_valid, b_ready, b_id} = {1'b1, rand_bits(2) != 0, ID_W'(id)};
            if (b_ready && done[id] > 0) done[id]--;
            else if (b_ready) f[B_EARLY] = 1'b1;   // Nothing finished on this ID
         end
      end
      if (wq.size() > 0 && rand_bits(2) != 0) begin
         d     = wq[0];
         a     = (w_beat == 0) ? d.addr : w_addr;
         lanes = lanes_for(a, d.size);
         last  = (w_beat == int'(d.len));
         {w_valid, w_ready, w_last} = {1'b1, rand_bits(2) != 0, last};
         w_strb = STRB_W'(rand_bits(STRB_W)) & lanes;
         if (inject && rand_bits(3) == 0) begin
            lane = rand_bits($clog2(STRB_W));
            w_strb[lane] = 1'b1;   // May fall outside the lanes
         end
         if (inject && rand_bits(3) == 0) w_last = !last;
         if (w_ready) begin
            f[W_LAST_MISSING] = last && !w_last;
            f[W_LAST_EARLY]   = !last && w_last;
            f[W_STRB_LANE]    = |(w_strb & ~lanes);
            if (last || w_last) begin   // Early WLAST ends the burst too
               void'(wq.pop_front());
               done[d.id]++;
               w_beat = 0;
            end else begin
               w_beat++;
               w_addr = step_addr(d, a);
            end
         end
      end
      if (rand_bits(1) == 1) begin
         id = rand_bits(ID_W);   // Random ID per beat interleaves the reads
         if (rq[id].size() > 0 || (inject && rand_bits(2) == 0)) begin
            last = (rq[id].size() > 0) && (r_beat[id] == rq[id][0]);
            {r_valid, r_ready, r_id, r_last} = {1'b1, rand_bits(2) != 0, ID_W'(id), last};
            if (inject && rand_bits(3) == 0) r_last = !last;
            if (r_ready && rq[id].size() == 0) begin
               f[R_UNEXPECTED] = 1'b1;
            end else if (r_ready) begin
               f[R_LAST_MISSING] = last && !r_last;
               f[R_LAST_EARLY]   = !last && r_last;
               if (last || r_last) begin
                  void'(rq[id].pop_front());
                  r_beat[id] = 0;
               end else begin
                  r_beat[id]++;
               end
            end
         end
      end
      if (aw_valid && aw_ready) wq.push_back(aw_new);
      if (ar_valid && ar_ready) rq[ar_pick].push_back(int'(ar_len));
      stage1 = f;
   endtask

   // Outputs after an edge show the handshakes of two edges back
   task automatic run_cycles(input string name, input int n, input bit inject, input bit issue);
      repeat (n) begin
         @(posedge clk);
         #2;
         exp_mask = exp_mask | stage2;
         check_code(name, |stage2, lowest_code(stage2));
         check_mask(name, exp_mask);
         stage2 = stage1;
         drive_cycle(inject, issue);
      end
   endtask

   task automatic drain(input string name);
      for (int t = 0; t < 500 && !model_idle(); t++) run_cycles(name, 1, 1'b0, 1'b0);
      if (!model_idle()) stop_with_failure({name, ": bursts still open after 500 cycles"});
      run_cycles(name, 2, 1'b0, 1'b0);   // Let the last pulses come out
   endtask

   task automatic apply_reset();
      set_idle();
      rst_req = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      rst_req = 1'b0;
      clear_model();
   endtask

   initial begin
      set_idle();
      rst_req = 1'b0;
      clear_model();
      for (int t = 0; t < 10 && rst_n !== 1'b0; t++) @(posedge clk);
      if (rst_n !== 1'b0) stop_with_failure("reset was never released");
      run_cycles("legal traffic", 1500, 1'b0, 1'b1);
      drain("legal drain");
      check_mask("legal traffic", '0);
      run_cycles("injected errors", 2500, 1'b1, 1'b1);
      drain("error drain");
      if (exp_mask !== '1) stop_with_failure("the injected traffic missed some violation codes");
      apply_reset();
      run_cycles("second reset", 5, 1'b0, 1'b0);
      check_mask("second reset", '0);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- test/tb_clock.sv
// Testbench clock and reset source; 20 ns clock, reset held for the first two cycles
`timescale 1ns/1ps

module tb_clock (
   input  logic rst_req,   // Extra reset requested by the test sequence
   output logic clk,
   output logic rst_n
);
   logic rst_init;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   initial begin
      rst_init = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      rst_init = 1'b0;   // Released just after the second edge
   end

   assign rst_n = rst_init | rst_req;   // Active high

endmodule
